// ==== verilog/fetch_pkg.sv ====
// shared widths, branch opcode decode and packed structs of the fetch unit, used by scoped names
package fetch_pkg;

  localparam int SLOTS  = 8;
  localparam int INST_W = 32;
  localparam int ADDR_W = 64;
  localparam int POS_W  = $clog2(SLOTS);
  localparam int DISP_W = 21;

  // alpha branch opcodes
  localparam logic [5:0] OPC_BR      = 6'h30;
  localparam logic [5:0] OPC_BSR     = 6'h34;
  // 0x38 to 0x3f are the conditional branches
  localparam logic [2:0] OPC_COND_HI = 3'b111;

  typedef logic [SLOTS-1:0] slot_mask_t;
  // slot 0 sits in the low word
  typedef logic [SLOTS-1:0][INST_W-1:0] inst_bundle_t;

  typedef enum logic [1:0] {
    BR_NONE   = 2'd0,
    BR_COND   = 2'd1,
    BR_UNCOND = 2'd2
  } br_kind_e;

  typedef struct packed {
    logic              hit;
    br_kind_e          kind;
    logic [POS_W-1:0]  pos;
    logic [ADDR_W-1:0] target;
  } btb_lookup_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    logic [POS_W-1:0]  pos;
    br_kind_e          kind;
    logic [ADDR_W-1:0] target;
  } btb_write_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    inst_bundle_t      insts;
    slot_mask_t        mask;
    logic              btb_hit;
  } f1_item_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    slot_mask_t        mask;
    inst_bundle_t      insts;
  } fetch_bundle_t;

  // classify one instruction by its opcode
  function automatic br_kind_e br_kind(input logic [INST_W-1:0] inst);
    br_kind_e kind;
    kind = BR_NONE;
    if (inst[31:26] == OPC_BR || inst[31:26] == OPC_BSR) begin
      kind = BR_UNCOND;
    end else if (inst[31:29] == OPC_COND_HI) begin
      kind = BR_COND;
    end
    return kind;
  endfunction

  // slots 0 up to and including pos
  function automatic slot_mask_t thru_mask(input logic [POS_W-1:0] pos);
    slot_mask_t mask;
    for (int i = 0; i < SLOTS; i++) begin
      mask[i] = (i <= int'(pos));
    end
    return mask;
  endfunction

endpackage

// ==== verilog/fetch_btb.sv ====
// direct-mapped branch target buffer, looked up combinationally by f0 and filled by f1
`timescale 1ns/1ps

module fetch_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                         clock,
  input  logic                         reset_n,
  input  logic [fetch_pkg::ADDR_W-1:0] lookup_pc_i,
  output fetch_pkg::btb_lookup_t       lookup_o,
  input  fetch_pkg::btb_write_t        write_i
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = fetch_pkg::ADDR_W - IDX_W - 2;

  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    fetch_pkg::br_kind_e          kind;
    logic [fetch_pkg::POS_W-1:0]  pos;
    logic [fetch_pkg::ADDR_W-1:0] target;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] valid_q;
  btb_entry_t             table_q [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  btb_entry_t       rd_entry;
  logic             rd_hit;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  // word address bits index, the rest is tag
  assign rd_idx   = lookup_pc_i[2 +: IDX_W];
  assign rd_tag   = lookup_pc_i[fetch_pkg::ADDR_W-1 -: TAG_W];
  assign rd_entry = table_q[rd_idx];
  assign rd_hit   = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

  assign lookup_o.hit    = rd_hit;
  assign lookup_o.kind   = rd_hit ? rd_entry.kind : fetch_pkg::BR_NONE;
  assign lookup_o.pos    = rd_entry.pos;
  assign lookup_o.target = rd_entry.target;

  //////////////////////////////////////////////////
  // fill from f1
  //////////////////////////////////////////////////

  assign wr_idx = write_i.pc[2 +: IDX_W];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (write_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // a same-cycle read still returns the old entry
  always_ff @(posedge clock) begin
    if (write_i.valid) begin
      table_q[wr_idx].tag    <= write_i.pc[fetch_pkg::ADDR_W-1 -: TAG_W];
      table_q[wr_idx].kind   <= write_i.kind;
      table_q[wr_idx].pos    <= write_i.pos;
      table_q[wr_idx].target <= write_i.target;
    end
  end

endmodule

// ==== verilog/fetch_stage0.sv ====
// fetch stage f0: PC register, next-PC selection, BTB slot mask and the f0 to f1 pipe register
`timescale 1ns/1ps

module fetch_stage0 #(
  parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = '0
) (
  input  logic                         clock,
  input  logic                         reset_n,
  input  logic                         flush_i,
  input  logic [fetch_pkg::ADDR_W-1:0] flush_pc_i,
  input  logic                         advance_i,
  input  fetch_pkg::redirect_t         redirect_i,
  input  fetch_pkg::btb_lookup_t       btb_i,
  input  fetch_pkg::inst_bundle_t      inst_bundle_i,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_addr_o,
  output fetch_pkg::f1_item_t          f1_item_o
);

  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_next;
  logic [fetch_pkg::ADDR_W-1:0] pc_after_br;
  fetch_pkg::slot_mask_t        f0_mask;
  logic                         load;

  // f1 pipe register
  logic                         valid_f1_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_f1_q;
  fetch_pkg::inst_bundle_t      insts_f1_q;
  fetch_pkg::slot_mask_t        mask_f1_q;
  logic                         hit_f1_q;

  assign fetch_addr_o = pc_q;
  assign load         = advance_i | flush_i;

  //////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////

  // not-taken path past a predicted branch
  assign pc_after_br = pc_q + {{(fetch_pkg::ADDR_W-fetch_pkg::POS_W-2){1'b0}}, btb_i.pos, 2'b00}
                     + fetch_pkg::ADDR_W'(4);

  always_comb begin
    if (flush_i) begin
      pc_next = flush_pc_i;
    end else if (redirect_i.valid) begin
      pc_next = redirect_i.pc;
    end else if (btb_i.hit && btb_i.kind == fetch_pkg::BR_UNCOND) begin
      pc_next = btb_i.target;
    end else if (btb_i.hit) begin
      // conditionals are statically not taken
      pc_next = pc_after_br;
    end else begin
      pc_next = pc_q + fetch_pkg::ADDR_W'(32);
    end
  end

  // keep slots up to the predicted branch
  assign f0_mask = btb_i.hit ? fetch_pkg::thru_mask(btb_i.pos) : '1;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc_q <= RESET_PC;
    end else if (load) begin
      pc_q <= pc_next;
    end
  end

  //////////////////////////////////////////////////
  // f0 to f1
  //////////////////////////////////////////////////

  // an f1 redirect kills the bundle fetched this cycle
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_f1_q <= 1'b0;
    end else if (load) begin
      valid_f1_q <= ~flush_i & ~redirect_i.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      pc_f1_q    <= pc_q;
      insts_f1_q <= inst_bundle_i;
      mask_f1_q  <= f0_mask;
      hit_f1_q   <= btb_i.hit;
    end
  end

  // retire flush kills whatever sits in f1
  assign f1_item_o.valid   = valid_f1_q & ~flush_i;
  assign f1_item_o.pc      = pc_f1_q;
  assign f1_item_o.insts   = insts_f1_q;
  assign f1_item_o.mask    = mask_f1_q;
  assign f1_item_o.btb_hit = hit_f1_q;

endmodule

// ==== verilog/branch_predecode.sv ====
// f1 predecode, finds the first valid branch of a bundle and computes its displacement target
`timescale 1ns/1ps

module branch_predecode (
  input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  fetch_pkg::inst_bundle_t      insts_i,
  input  fetch_pkg::slot_mask_t        mask_i,
  output fetch_pkg::br_kind_e          kind_o,
  output logic [fetch_pkg::POS_W-1:0]  pos_o,
  output logic [fetch_pkg::ADDR_W-1:0] target_o
);

  logic [fetch_pkg::INST_W-1:0] br_inst;
  logic [fetch_pkg::DISP_W-1:0] disp;
  logic [fetch_pkg::ADDR_W-1:0] br_pc;
  logic [fetch_pkg::ADDR_W-1:0] disp_ext;

  //////////////////////////////////////////////////
  // first branch scan
  //////////////////////////////////////////////////

  always_comb begin
    kind_o = fetch_pkg::BR_NONE;
    pos_o  = '0;
    // walk downward so the lowest slot wins
    for (int i = fetch_pkg::SLOTS - 1; i >= 0; i--) begin
      if (mask_i[i] && fetch_pkg::br_kind(insts_i[i]) != fetch_pkg::BR_NONE) begin
        kind_o = fetch_pkg::br_kind(insts_i[i]);
        pos_o  = i[fetch_pkg::POS_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // target
  //////////////////////////////////////////////////

  assign br_inst = insts_i[pos_o];
  assign disp    = br_inst[fetch_pkg::DISP_W-1:0];

  // pc of the branch itself
  assign br_pc = pc_i + {{(fetch_pkg::ADDR_W-fetch_pkg::POS_W-2){1'b0}}, pos_o, 2'b00};

  // word displacement, sign extended
  assign disp_ext = {{(fetch_pkg::ADDR_W-fetch_pkg::DISP_W-2){disp[fetch_pkg::DISP_W-1]}},
                     disp, 2'b00};

  assign target_o = br_pc + fetch_pkg::ADDR_W'(4) + disp_ext;

endmodule

// ==== verilog/fetch_stage1.sv ====
// fetch stage f1: predecode override, BTB fill, decode credit counter and output bundle register
`timescale 1ns/1ps

module fetch_stage1 #(
  parameter int IBUF_CREDITS = 4
) (
  input  logic                         clock,
  input  logic                         reset_n,
  input  fetch_pkg::f1_item_t          f1_item_i,
  input  fetch_pkg::br_kind_e          kind_i,
  input  logic [fetch_pkg::POS_W-1:0]  pos_i,
  input  logic [fetch_pkg::ADDR_W-1:0] target_i,
  input  logic                         credit_return_i,
  output logic                         advance_o,
  output fetch_pkg::redirect_t         redirect_o,
  output fetch_pkg::btb_write_t        btb_write_o,
  output fetch_pkg::fetch_bundle_t     bundle_o
);

  localparam int CNT_W = $clog2(IBUF_CREDITS + 1);

  logic                  learn;
  logic                  override;
  fetch_pkg::slot_mask_t out_mask;
  logic                  need_credit;
  logic                  credit_ok;
  logic                  send;
  logic [CNT_W-1:0]      credit_q;

  // output register
  logic                         valid_d0_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_d0_q;
  fetch_pkg::slot_mask_t        mask_d0_q;
  fetch_pkg::inst_bundle_t      insts_d0_q;

  //////////////////////////////////////////////////
  // override and BTB fill
  //////////////////////////////////////////////////

  // branch found that the BTB did not know about
  assign learn    = f1_item_i.valid && !f1_item_i.btb_hit && kind_i != fetch_pkg::BR_NONE;
  assign override = learn && kind_i == fetch_pkg::BR_UNCOND;

  // cut the bundle after a missed unconditional branch
  assign out_mask = override ? (f1_item_i.mask & fetch_pkg::thru_mask(pos_i)) : f1_item_i.mask;

  assign redirect_o.valid = override & advance_o;
  assign redirect_o.pc    = target_i;

  assign btb_write_o.valid  = learn & advance_o;
  assign btb_write_o.pc     = f1_item_i.pc;
  assign btb_write_o.pos    = pos_i;
  assign btb_write_o.kind   = kind_i;
  assign btb_write_o.target = target_i;

  //////////////////////////////////////////////////
  // credits
  //////////////////////////////////////////////////

  // empty or killed items pass without a credit
  assign need_credit = f1_item_i.valid & (|f1_item_i.mask);
  // a return in this cycle counts as available
  assign credit_ok   = (credit_q != '0) | credit_return_i;
  assign advance_o   = ~need_credit | credit_ok;
  assign send        = need_credit & credit_ok;

  // credit is taken as the bundle is loaded into the output register
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      credit_q <= CNT_W'(IBUF_CREDITS);
    end else begin
      credit_q <= credit_q + CNT_W'(credit_return_i) - CNT_W'(send);
    end
  end

  //////////////////////////////////////////////////
  // bundle to decode
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_d0_q <= 1'b0;
    end else begin
      valid_d0_q <= send;
    end
  end

  always_ff @(posedge clock) begin
    if (send) begin
      pc_d0_q    <= f1_item_i.pc;
      mask_d0_q  <= out_mask;
      insts_d0_q <= f1_item_i.insts;
    end
  end

  assign bundle_o.valid = valid_d0_q;
  assign bundle_o.pc    = pc_d0_q;
  assign bundle_o.mask  = mask_d0_q;
  assign bundle_o.insts = insts_d0_q;

endmodule

// ==== verilog/fetch_unit.sv ====
// top of the two-stage fetch unit, connects the BTB, the f0 and f1 stages and predecode
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC     = 64'h0000_0000_0000_1000,
  parameter int                           BTB_ENTRIES  = 16,
  parameter int                           IBUF_CREDITS = 4
) (
  input  logic                         clock,
  input  logic                         reset_n,
  // retire
  input  logic                         flush_i,
  input  logic [fetch_pkg::ADDR_W-1:0] flush_pc_i,
  // icache
  input  fetch_pkg::inst_bundle_t      inst_bundle_i,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_addr_o,
  // decode
  input  logic                         credit_return_i,
  output fetch_pkg::fetch_bundle_t     bundle_o
);

  fetch_pkg::btb_lookup_t       btb_lookup;
  fetch_pkg::btb_write_t        btb_write;
  fetch_pkg::redirect_t         redirect;
  fetch_pkg::f1_item_t          f1_item;
  fetch_pkg::br_kind_e          pd_kind;
  logic [fetch_pkg::POS_W-1:0]  pd_pos;
  logic [fetch_pkg::ADDR_W-1:0] pd_target;
  logic                         advance;

  //////////////////////////////////////////////////
  // f0
  //////////////////////////////////////////////////

  fetch_btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) fetch_btb_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .lookup_pc_i (fetch_addr_o),
    .lookup_o    (btb_lookup),
    .write_i     (btb_write)
  );

  fetch_stage0 #(
    .RESET_PC (RESET_PC)
  ) fetch_stage0_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .advance_i     (advance),
    .redirect_i    (redirect),
    .btb_i         (btb_lookup),
    .inst_bundle_i (inst_bundle_i),
    .fetch_addr_o  (fetch_addr_o),
    .f1_item_o     (f1_item)
  );

  //////////////////////////////////////////////////
  // f1
  //////////////////////////////////////////////////

  branch_predecode branch_predecode_i (
    .pc_i     (f1_item.pc),
    .insts_i  (f1_item.insts),
    .mask_i   (f1_item.mask),
    .kind_o   (pd_kind),
    .pos_o    (pd_pos),
    .target_o (pd_target)
  );

  fetch_stage1 #(
    .IBUF_CREDITS (IBUF_CREDITS)
  ) fetch_stage1_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .f1_item_i       (f1_item),
    .kind_i          (pd_kind),
    .pos_i           (pd_pos),
    .target_i        (pd_target),
    .credit_return_i (credit_return_i),
    .advance_o       (advance),
    .redirect_o      (redirect),
    .btb_write_o     (btb_write),
    .bundle_o        (bundle_o)
  );

endmodule

// ==== include/fetch_tb_program.svh ====
// program image and stimulus rows of the fetch unit testbench, included inside the testbench module
`ifndef FETCH_TB_PROGRAM_SVH
`define FETCH_TB_PROGRAM_SVH

localparam logic [63:0] PROG_BASE  = 64'h1000;
localparam int          PROG_WORDS = 128;

// credit return modes
localparam int MODE_PROMPT   = 0;
localparam int MODE_THROTTLE = 1;
localparam int MODE_WITHHOLD = 2;

typedef struct packed {
  logic [63:0] pc;
  int          count;
  int          mode;
} stim_row_t;

localparam int NUM_ROWS = 4;

// columns: flush pc, instructions to check, credit mode
// row 0 starts from reset and does not flush
localparam stim_row_t ROWS [NUM_ROWS] = '{
  '{pc: 64'h1000, count: 60, mode: MODE_WITHHOLD},
  '{pc: 64'h1104, count: 40, mode: MODE_THROTTLE},
  '{pc: 64'h1010, count: 40, mode: MODE_PROMPT},
  '{pc: 64'h1000, count: 50, mode: MODE_THROTTLE}
};

logic [31:0] prog_mem [PROG_WORDS];

task automatic load_program();
  // plain operate instructions everywhere
  for (int i = 0; i < PROG_WORDS; i++) begin
    prog_mem[i] = 32'h4000_0000 | 32'(i);
  end
  // beq at 0x1010, falls through under the static rule
  prog_mem[4]  = 32'hE420_0005;
  // br at 0x1034 back to 0x1008 closes the loop
  prog_mem[13] = 32'hC3FF_FFF4;
  // bsr at 0x111c jumps to 0x1000
  prog_mem[71] = 32'hD35F_FFB8;
endtask

`endif

// ==== verif/fetch_unit_tb.sv ====
// simulation top of the fetch unit, checks its bundle stream against a reference walker
`timescale 1ns/1ps

module fetch_unit_tb;

  localparam logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 64'h1000;
  localparam int IBUF_CREDITS = 4;
  localparam int WAIT_LIMIT   = 3000;
  localparam int QUIET_CYCLES = 50;

  logic                         clock;
  logic                         reset_n;
  logic                         flush_i;
  logic [fetch_pkg::ADDR_W-1:0] flush_pc_i;
  fetch_pkg::inst_bundle_t      inst_bundle_i;
  logic                         credit_return_i;
  logic [fetch_pkg::ADDR_W-1:0] fetch_addr_o;
  fetch_pkg::fetch_bundle_t     bundle_o;

  `include "fetch_tb_program.svh"

  int          value_errs;
  int          other_errs;
  int          sent;
  int          returned;
  int          insts_seen;
  int          credit_mode;
  logic [63:0] exp_pc;
  logic        addr_pending;
  logic [63:0] pending_pc;
  logic [31:0] lfsr;

  fetch_unit #(
    .RESET_PC     (RESET_PC),
    .BTB_ENTRIES  (16),
    .IBUF_CREDITS (IBUF_CREDITS)
  ) fetch_unit_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .flush_i         (flush_i),
    .flush_pc_i      (flush_pc_i),
    .inst_bundle_i   (inst_bundle_i),
    .credit_return_i (credit_return_i),
    .fetch_addr_o    (fetch_addr_o),
    .bundle_o        (bundle_o)
  );

  always #50 clock = ~clock;

  //////////////////////////////////////////////////
  // memory model and reference walker
  //////////////////////////////////////////////////

  function automatic logic [31:0] fetch_word(input logic [63:0] addr);
    logic [63:0] word_addr;
    logic [63:0] offset;
    word_addr = addr >> 2;
    offset    = addr - PROG_BASE;
    if (addr >= PROG_BASE && offset < 64'(PROG_WORDS * 4)) begin
      return prog_mem[int'(offset >> 2)];
    end
    // non-branch fill folded from every address bit
    return {6'h11, 26'(word_addr ^ (word_addr >> 26) ^ (word_addr >> 52))};
  endfunction

  always_comb begin
    for (int k = 0; k < fetch_pkg::SLOTS; k++) begin
      inst_bundle_i[k] = fetch_word(fetch_addr_o + 64'(4 * k));
    end
  end

  // br and bsr
  function automatic logic is_uncond(input logic [31:0] inst);
    return inst[31:26] == 6'h30 || inst[31:26] == 6'h34;
  endfunction

  function automatic logic [63:0] walk_next(input logic [63:0] pc);
    logic [31:0] inst;
    logic [63:0] disp;
    inst = fetch_word(pc);
    disp = {{43{inst[20]}}, inst[20:0]};
    if (is_uncond(inst)) begin
      return pc + 64'd4 + (disp << 2);
    end
    return pc + 64'd4;
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic compare_addr(input string name, input logic [fetch_pkg::ADDR_W-1:0] got,
                              input logic [fetch_pkg::ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic compare_inst(input string name, input logic [fetch_pkg::INST_W-1:0] got,
                              input logic [fetch_pkg::INST_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic compare_mask(input string name, input fetch_pkg::slot_mask_t got,
                              input fetch_pkg::slot_mask_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // contiguous mask from slot 0 and slots that follow the walker
  task automatic check_bundle(input fetch_pkg::fetch_bundle_t b);
    int                    n;
    fetch_pkg::slot_mask_t want;
    n    = 0;
    want = '0;
    for (int k = 0; k < fetch_pkg::SLOTS; k++) begin
      if (b.mask[k]) begin
        n++;
      end
    end
    for (int k = 0; k < n; k++) begin
      want[k] = 1'b1;
    end
    compare_mask("bundle_o.mask", b.mask, want);
    if (n == 0) begin
      $display("%0t: a bundle was sent with no valid slot", $time);
      other_errs++;
    end
    for (int k = 0; k < n; k++) begin
      compare_addr($sformatf("bundle_o.pc + %0d", 4 * k), b.pc + 64'(4 * k), exp_pc);
      compare_inst($sformatf("bundle_o.insts[%0d]", k), b.insts[k], fetch_word(exp_pc));
      if (is_uncond(b.insts[k]) && k < n - 1) begin
        $display("%0t: bundle continues past an unconditional branch in slot %0d", $time, k);
        other_errs++;
      end
      exp_pc = walk_next(exp_pc);
      insts_seen++;
    end
  endtask

  // sample the cycle that just ended and drive the next one
  task automatic step_cycle(input logic do_flush, input logic [63:0] pc);
    int   owed;
    logic ret;
    @(posedge clock);
    if (credit_return_i) begin
      returned++;
    end
    if (bundle_o.valid) begin
      sent++;
      check_bundle(bundle_o);
    end
    if (sent - returned > IBUF_CREDITS) begin
      $display("%0t: more bundles outstanding than credits", $time);
      other_errs++;
    end
    if (addr_pending) begin
      compare_addr("fetch_addr_o", fetch_addr_o, pending_pc);
      addr_pending = 1'b0;
    end
    // bundles from the next cycle on belong to the new path
    if (flush_i) begin
      exp_pc       = flush_pc_i;
      pending_pc   = flush_pc_i;
      addr_pending = 1'b1;
      insts_seen   = 0;
    end
    owed = sent - returned;
    ret  = 1'b0;
    if (owed > 0 && credit_mode == MODE_PROMPT) begin
      ret = 1'b1;
    end else if (owed > 0 && credit_mode == MODE_THROTTLE) begin
      lfsr = lfsr_step(lfsr);
      ret  = lfsr[0];
    end
    credit_return_i <= ret;
    flush_i         <= do_flush;
    flush_pc_i      <= pc;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int timer;
    int sent_before;
    clock           = 1'b0;
    reset_n         = 1'b0;
    flush_i         = 1'b0;
    flush_pc_i      = '0;
    credit_return_i = 1'b0;
    value_errs      = 0;
    other_errs      = 0;
    sent            = 0;
    returned        = 0;
    insts_seen      = 0;
    credit_mode     = MODE_PROMPT;
    exp_pc          = RESET_PC;
    addr_pending    = 1'b0;
    pending_pc      = '0;
    lfsr            = 32'hff95;
    load_program();

    repeat (5) @(posedge clock);
    compare_bit("bundle_o.valid", bundle_o.valid, 1'b0);
    compare_addr("fetch_addr_o", fetch_addr_o, RESET_PC);
    reset_n <= 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      credit_mode = ROWS[r].mode;
      if (r > 0) begin
        step_cycle(1'b1, ROWS[r].pc);
        step_cycle(1'b0, '0);
      end
      if (credit_mode == MODE_WITHHOLD) begin
        timer = 0;
        while (sent - returned < IBUF_CREDITS && timer < WAIT_LIMIT) begin
          step_cycle(1'b0, '0);
          timer++;
        end
        if (timer >= WAIT_LIMIT) begin
          $display("%0t: credits were never used up while withheld", $time);
          other_errs++;
        end
        sent_before = sent;
        repeat (QUIET_CYCLES) step_cycle(1'b0, '0);
        if (sent != sent_before) begin
          $display("%0t: bundles kept coming with no credit left", $time);
          other_errs++;
        end
        credit_mode = MODE_PROMPT;
      end
      timer = 0;
      while (insts_seen < ROWS[r].count && timer < WAIT_LIMIT) begin
        step_cycle(1'b0, '0);
        timer++;
      end
      if (timer >= WAIT_LIMIT) begin
        $display("%0t: row %0d saw only %0d of %0d instructions", $time, r, insts_seen,
                 ROWS[r].count);
        other_errs++;
      end
    end

    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_btb.sv
verilog/fetch_stage0.sv
verilog/branch_predecode.sv
verilog/fetch_stage1.sv
verilog/fetch_unit.sv
verif/fetch_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compiles the fetch unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f build.f --top-module fetch_unit_tb -o fetch_unit_tb_sim

./obj_dir/fetch_unit_tb_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
